// ==== verilog/issue_pkg.sv ====
/*
 Shared sizes, encodings and helper functions of the issue slice.
 Sequence numbers wrap at 256 and age is taken from their difference,
 so fewer than 128 instructions may be in flight at any time.
 Each queue entry carries its own slot index so results can find it.
*/
`default_nettype none

package issue_pkg;

	// =========================================================
	// Sizes
	// =========================================================
	localparam int IQ_ENTRIES = 8;
	localparam int QBITS = 3;
	localparam int SN_BITS = 8;
	localparam int DATA_BITS = 16;
	localparam int CREDIT_BITS = 4;

	typedef enum logic [2:0] {op_add, op_sub, op_beq, op_blt, op_jmp} op_e;
	typedef enum logic [1:0] {iqs_invalid, iqs_queued, iqs_issued} iq_state_e;

	typedef struct packed {
		op_e op;
		logic [SN_BITS-1:0] sn;
		logic [QBITS-1:0] qid;
		logic [DATA_BITS-1:0] a;
		logic [DATA_BITS-1:0] b;
		logic pred;
	} iq_entry_t;

	typedef struct packed {
		logic [SN_BITS-1:0] sn;
		logic [QBITS-1:0] qid;
		logic [DATA_BITS-1:0] data;
		logic miss;
	} wb_result_t;

	// =========================================================
	// Age and opcode helpers
	// =========================================================

	// True when x comes after y in program order
	function automatic logic sn_younger(input logic [SN_BITS-1:0] x,
		input logic [SN_BITS-1:0] y);
		logic [SN_BITS-1:0] diff;
		diff = x - y;
		return (diff != '0) && !diff[SN_BITS-1];
	endfunction

	function automatic logic is_fc(input op_e op);
		return (op == op_beq) || (op == op_blt) || (op == op_jmp);
	endfunction

	// One-hot of the oldest candidate, zero when there is none
	function automatic logic [IQ_ENTRIES-1:0] pick_oldest(
		input logic [IQ_ENTRIES-1:0] cand,
		input logic [IQ_ENTRIES-1:0][SN_BITS-1:0] sns);
		logic [IQ_ENTRIES-1:0] pick;
		pick = '0;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			pick[i] = cand[i];
			// Any older candidate knocks this one out
			for (int j = 0; j < IQ_ENTRIES; j++)
				if (j != i && cand[j] && sn_younger(sns[i], sns[j]))
					pick[i] = 1'b0;
		end
		return pick;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/wb_if.sv ====
/*
 Writeback link between one execution unit and the arbiter.
 The unit holds valid and result steady until grant is seen, and the
 transfer takes place in the cycle where valid and grant are both high.
*/
`default_nettype none

interface wb_if;
	logic valid;
	issue_pkg::wb_result_t result;
	logic grant;

	// Unit side drives the result, arbiter side answers with grant
	modport unit (output valid, output result, input grant);
	modport arbiter (input valid, input result, output grant);
endinterface

`default_nettype wire

// ==== verilog/issue_queue.sv ====
/*
 Eight-entry issue queue with dispatch, ALU pick, retirement and flush.
 The front end must hold a credit for every dispatch, and credits come
 back on credit_ret one cycle after the entry is freed.
 Dispatches arriving during a mispredict are dropped by sn and their
 credit is returned with the flushed entries.
*/
`default_nettype none

module issue_queue (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  issue_pkg::op_e in_op,
	input  logic [issue_pkg::SN_BITS-1:0] in_sn,
	input  logic [issue_pkg::DATA_BITS-1:0] in_a,
	input  logic [issue_pkg::DATA_BITS-1:0] in_b,
	input  logic in_pred,
	input  logic [issue_pkg::IQ_ENTRIES-1:0] fcu_pick,
	output issue_pkg::iq_state_e [issue_pkg::IQ_ENTRIES-1:0] iq_state,
	output issue_pkg::op_e [issue_pkg::IQ_ENTRIES-1:0] iq_op,
	output logic [issue_pkg::IQ_ENTRIES-1:0][issue_pkg::SN_BITS-1:0] iq_sn,
	output issue_pkg::iq_entry_t fcu_entry,
	output logic fcu_start,
	output issue_pkg::iq_entry_t alu_entry,
	output logic alu_start,
	input  logic alu_free,
	input  logic wb_valid,
	input  issue_pkg::wb_result_t wb,
	output logic [issue_pkg::CREDIT_BITS-1:0] credit_ret,
	output logic flush,
	output logic [issue_pkg::SN_BITS-1:0] flush_sn,
	output logic branch_miss
);
	localparam int N = issue_pkg::IQ_ENTRIES;

	issue_pkg::iq_state_e [N-1:0] state_q;
	issue_pkg::iq_state_e [N-1:0] state_nxt;
	issue_pkg::iq_entry_t ent_q [N];
	logic [N-1:0] alu_cand;
	logic [N-1:0] alu_pick;
	logic [issue_pkg::QBITS-1:0] alloc_idx;
	logic full;
	logic miss_now;
	logic drop_in;
	logic [issue_pkg::CREDIT_BITS-1:0] freed;

	// A mispredicted branch is being written back this cycle
	assign miss_now = wb_valid && wb.miss;
	// FCU issue stays blocked from the grant until the flush has been applied
	assign branch_miss = miss_now || flush;

	always_comb begin
		iq_state = state_q;
		for (int i = 0; i < N; i++) begin
			iq_op[i] = ent_q[i].op;
			iq_sn[i] = ent_q[i].sn;
		end
	end

	// Lowest free slot takes the next dispatch
	always_comb begin
		alloc_idx = '0;
		full = 1'b1;
		for (int i = N - 1; i >= 0; i--) begin
			if (state_q[i] == issue_pkg::iqs_invalid) begin
				alloc_idx = issue_pkg::QBITS'(i);
				full = 1'b0;
			end
		end
	end

	// =========================================================
	// ALU pick
	// =========================================================
	// An ALU op right behind a queued jmp waits for the jmp to issue,
	// otherwise it could retire and leave the jmp without a successor
	always_comb begin
		for (int i = 0; i < N; i++) begin
			alu_cand[i] = (state_q[i] == issue_pkg::iqs_queued)
				&& !issue_pkg::is_fc(ent_q[i].op);
			for (int j = 0; j < N; j++)
				if (state_q[j] == issue_pkg::iqs_queued && ent_q[j].op == issue_pkg::op_jmp
					&& ent_q[i].sn == issue_pkg::SN_BITS'(ent_q[j].sn + 1'b1))
					alu_cand[i] = 1'b0;
		end
		alu_pick = alu_free ? issue_pkg::pick_oldest(alu_cand, iq_sn) : '0;
	end

	// Entry muxes toward the two units
	always_comb begin
		fcu_entry = ent_q[0];
		alu_entry = ent_q[0];
		for (int i = 0; i < N; i++) begin
			if (fcu_pick[i])
				fcu_entry = ent_q[i];
			if (alu_pick[i])
				alu_entry = ent_q[i];
		end
	end

	assign fcu_start = |fcu_pick;
	assign alu_start = |alu_pick;

	// =========================================================
	// Next state, flush and credit count
	// =========================================================
	always_comb begin
		state_nxt = state_q;
		drop_in = 1'b0;
		freed = '0;
		for (int i = 0; i < N; i++)
			if (fcu_pick[i] || alu_pick[i])
				state_nxt[i] = issue_pkg::iqs_issued;
		// Granted result frees its slot
		if (wb_valid)
			state_nxt[wb.qid] = issue_pkg::iqs_invalid;
		// Everything younger than the missed branch goes away
		if (miss_now)
			for (int i = 0; i < N; i++)
				if (state_q[i] != issue_pkg::iqs_invalid
					&& issue_pkg::sn_younger(ent_q[i].sn, wb.sn))
					state_nxt[i] = issue_pkg::iqs_invalid;
		// Wrong-path dispatches still in transit are dropped
		if (in_valid) begin
			if ((miss_now && issue_pkg::sn_younger(in_sn, wb.sn))
				|| (flush && issue_pkg::sn_younger(in_sn, flush_sn)))
				drop_in = 1'b1;
			else
				state_nxt[alloc_idx] = issue_pkg::iqs_queued;
		end
		if (drop_in)
			freed = freed + issue_pkg::CREDIT_BITS'(1);
		for (int i = 0; i < N; i++)
			if (state_q[i] != issue_pkg::iqs_invalid && state_nxt[i] == issue_pkg::iqs_invalid)
				freed = freed + issue_pkg::CREDIT_BITS'(1);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < N; i++)
				state_q[i] <= issue_pkg::iqs_invalid;
			credit_ret <= '0;
			flush <= 1'b0;
		end else begin
			state_q <= state_nxt;
			credit_ret <= freed;
			flush <= miss_now;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && !drop_in)
			ent_q[alloc_idx] <= '{op: in_op, sn: in_sn, qid: alloc_idx,
				a: in_a, b: in_b, pred: in_pred};
		if (miss_now)
			flush_sn <= wb.sn;
	end

	// Credit flow control never lets the front end overfill the queue
	assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> !full);
	// The selector hands over at most one entry per cycle
	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(fcu_pick));

endmodule

`default_nettype wire

// ==== verilog/fcu_issue.sv ====
/*
 Selects the one flow-control entry to send to the FCU this cycle.
 Purely combinational. A jmp waits until its successor in program
 order is queued, unless the queue is full and nothing else can arrive.
*/
`default_nettype none

module fcu_issue (
	input  issue_pkg::iq_state_e [issue_pkg::IQ_ENTRIES-1:0] iq_state,
	input  issue_pkg::op_e [issue_pkg::IQ_ENTRIES-1:0] iq_op,
	input  logic [issue_pkg::IQ_ENTRIES-1:0][issue_pkg::SN_BITS-1:0] iq_sn,
	input  logic fcu_done,
	input  logic branch_miss,
	output logic [issue_pkg::IQ_ENTRIES-1:0] pick
);
	localparam int N = issue_pkg::IQ_ENTRIES;

	logic [N-1:0] valid;
	logic [N-1:0] next_qd;
	logic [N-1:0] cand;
	logic full;

	always_comb begin
		for (int n = 0; n < N; n++)
			valid[n] = iq_state[n] != issue_pkg::iqs_invalid;
		full = &valid;
	end

	// Entry n has its successor queued when some valid entry holds sn + 1
	always_comb begin
		next_qd = '0;
		for (int n = 0; n < N; n++)
			for (int j = 0; j < N; j++)
				if (valid[j] && iq_sn[j] == issue_pkg::SN_BITS'(iq_sn[n] + 1'b1))
					next_qd[n] = 1'b1;
	end

	// Branches may always go, a jmp needs its successor or a full queue
	always_comb begin
		for (int n = 0; n < N; n++)
			cand[n] = (iq_state[n] == issue_pkg::iqs_queued)
				&& issue_pkg::is_fc(iq_op[n])
				&& (iq_op[n] != issue_pkg::op_jmp || next_qd[n] || full);
	end

	// Oldest ready entry wins, and only while the FCU is idle with no miss pending
	assign pick = (fcu_done && !branch_miss) ? issue_pkg::pick_oldest(cand, iq_sn) : '0;

endmodule

`default_nettype wire

// ==== verilog/fcu_unit.sv ====
/*
 Two-stage flow-control unit for beq, blt and jmp.
 Only one op is in flight, so done stays low from capture until the
 result has been granted on the writeback bus. blt compares unsigned.
*/
`default_nettype none

module fcu_unit (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  issue_pkg::iq_entry_t entry,
	output logic done,
	wb_if.unit wb
);
	issue_pkg::iq_entry_t s1_entry;
	issue_pkg::wb_result_t res_q;
	logic s1_valid;
	logic s1_taken;
	logic res_valid;
	logic taken;

	// Stage one condition
	always_comb begin
		case (entry.op)
			issue_pkg::op_beq: taken = entry.a == entry.b;
			issue_pkg::op_blt: taken = entry.a < entry.b;
			default: taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			res_valid <= 1'b0;
			done <= 1'b1;
		end else begin
			s1_valid <= start;
			if (s1_valid)
				res_valid <= 1'b1;
			else if (wb.grant)
				res_valid <= 1'b0;
			if (start)
				done <= 1'b0;
			else if (res_valid && wb.grant)
				done <= 1'b1;
		end
	end

	// Stage two result, a jmp returns its target a + b
	always_ff @(posedge clk) begin
		if (start) begin
			s1_entry <= entry;
			s1_taken <= taken;
		end
		if (s1_valid) begin
			res_q.sn <= s1_entry.sn;
			res_q.qid <= s1_entry.qid;
			if (s1_entry.op == issue_pkg::op_jmp) begin
				res_q.data <= s1_entry.a + s1_entry.b;
				res_q.miss <= 1'b0;
			end else begin
				res_q.data <= issue_pkg::DATA_BITS'(s1_taken);
				res_q.miss <= s1_taken != s1_entry.pred;
			end
		end
	end

	assign wb.valid = res_valid;
	assign wb.result = res_q;

	// The selector only issues while the previous op has been retired
	assert property (@(posedge clk) disable iff (!rst_n) start |-> done);

endmodule

`default_nettype wire

// ==== verilog/alu_unit.sv ====
/*
 One-stage add and subtract unit, results wrap modulo 2^16.
 A result waits in its register until granted. A flush that covers
 its sn hides it at once and drops it at the next edge.
*/
`default_nettype none

module alu_unit (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  issue_pkg::iq_entry_t entry,
	input  logic flush,
	input  logic [issue_pkg::SN_BITS-1:0] flush_sn,
	output logic free,
	wb_if.unit wb
);
	issue_pkg::wb_result_t res_q;
	logic res_valid;
	logic kill;

	assign kill = res_valid && flush && issue_pkg::sn_younger(res_q.sn, flush_sn);
	assign wb.valid = res_valid && !kill;
	assign wb.result = res_q;
	// New work may land when the register is empty or leaving this cycle
	assign free = !wb.valid || wb.grant;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			res_valid <= 1'b0;
		else if (start)
			res_valid <= 1'b1;
		else if ((wb.valid && wb.grant) || kill)
			res_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (start) begin
			res_q.sn <= entry.sn;
			res_q.qid <= entry.qid;
			res_q.data <= (entry.op == issue_pkg::op_sub) ? entry.a - entry.b
				: entry.a + entry.b;
			res_q.miss <= 1'b0;
		end
	end

	// Queue must honour back-pressure so a waiting result is never overwritten
	assert property (@(posedge clk) disable iff (!rst_n) start |-> free);

endmodule

`default_nettype wire

// ==== verilog/wb_arbiter.sv ====
/*
 Fixed-priority arbiter onto the single writeback bus, FCU first.
 The losing unit keeps its request up and is served on a later cycle.
*/
`default_nettype none

module wb_arbiter (
	input  logic clk,
	input  logic rst_n,
	wb_if.arbiter fcu,
	wb_if.arbiter alu,
	output logic wb_valid,
	output logic [issue_pkg::SN_BITS-1:0] wb_sn,
	output logic [issue_pkg::DATA_BITS-1:0] wb_data,
	output logic wb_miss,
	output issue_pkg::wb_result_t granted
);
	logic [2:0] alu_stall;

	assign fcu.grant = fcu.valid;
	assign alu.grant = alu.valid && !fcu.valid;

	// Bus mirrors whichever result is granted in the same cycle
	assign wb_valid = fcu.valid || alu.valid;
	assign granted = fcu.valid ? fcu.result : alu.result;
	assign wb_sn = granted.sn;
	assign wb_data = granted.data;
	assign wb_miss = granted.miss;

	// Consecutive cycles the ALU has waited behind the FCU
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			alu_stall <= '0;
		else if (alu.valid && !alu.grant)
			alu_stall <= alu_stall + 3'd1;
		else
			alu_stall <= '0;
	end

	// One FCU op in flight bounds how long the ALU can lose
	assert property (@(posedge clk) disable iff (!rst_n) alu_stall <= 3'd4);

endmodule

`default_nettype wire

// ==== verilog/issue_top.sv ====
/*
 Issue slice top level with plain ports toward the front end.
 The front end starts with eight credits, spends one per in_valid and
 adds credit_ret each cycle. After flush it resends from flush_sn + 1.
*/
`default_nettype none

module issue_top (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  issue_pkg::op_e in_op,
	input  logic [issue_pkg::SN_BITS-1:0] in_sn,
	input  logic [issue_pkg::DATA_BITS-1:0] in_a,
	input  logic [issue_pkg::DATA_BITS-1:0] in_b,
	input  logic in_pred,
	output logic [issue_pkg::CREDIT_BITS-1:0] credit_ret,
	output logic wb_valid,
	output logic [issue_pkg::SN_BITS-1:0] wb_sn,
	output logic [issue_pkg::DATA_BITS-1:0] wb_data,
	output logic wb_miss,
	output logic flush,
	output logic [issue_pkg::SN_BITS-1:0] flush_sn
);
	issue_pkg::iq_state_e [issue_pkg::IQ_ENTRIES-1:0] iq_state;
	issue_pkg::op_e [issue_pkg::IQ_ENTRIES-1:0] iq_op;
	logic [issue_pkg::IQ_ENTRIES-1:0][issue_pkg::SN_BITS-1:0] iq_sn;
	logic [issue_pkg::IQ_ENTRIES-1:0] fcu_pick;
	issue_pkg::iq_entry_t fcu_entry;
	issue_pkg::iq_entry_t alu_entry;
	issue_pkg::wb_result_t granted;
	logic fcu_start, fcu_done, alu_start, alu_free, branch_miss;

	wb_if fcu_wb ();
	wb_if alu_wb ();

	issue_queue queue_i (.clk, .rst_n, .in_valid, .in_op, .in_sn, .in_a, .in_b,
		.in_pred, .fcu_pick, .iq_state, .iq_op, .iq_sn, .fcu_entry, .fcu_start,
		.alu_entry, .alu_start, .alu_free, .wb_valid, .wb(granted), .credit_ret,
		.flush, .flush_sn, .branch_miss);

	fcu_issue fcu_issue_i (.iq_state, .iq_op, .iq_sn, .fcu_done, .branch_miss,
		.pick(fcu_pick));

	fcu_unit fcu_i (.clk, .rst_n, .start(fcu_start), .entry(fcu_entry),
		.done(fcu_done), .wb(fcu_wb.unit));

	alu_unit alu_i (.clk, .rst_n, .start(alu_start), .entry(alu_entry), .flush,
		.flush_sn, .free(alu_free), .wb(alu_wb.unit));

	wb_arbiter arb_i (.clk, .rst_n, .fcu(fcu_wb.arbiter), .alu(alu_wb.arbiter),
		.wb_valid, .wb_sn, .wb_data, .wb_miss, .granted);

endmodule

`default_nettype wire

// ==== bench/issue_tb.sv ====
/*
 Testbench for the issue slice top level.
 Random traffic comes from a fixed-seed LFSR, with a front-end model that
 holds credits and rewinds its sn counter after every flush.
 A directed phase holds a lone jmp and then releases it with a successor.
 The sn window stays well below 128 instructions in flight.
*/
`default_nettype none

module issue_tb;

	localparam int N_RAND = 150;
	localparam int HOLD_CYCLES = 20;
	localparam int TIMEOUT_CYCLES = 40 * (N_RAND + 2) + 200;

	logic clk;
	logic rst_n;
	logic in_valid;
	issue_pkg::op_e in_op;
	logic [7:0] in_sn;
	logic [15:0] in_a;
	logic [15:0] in_b;
	logic in_pred;
	logic [3:0] credit_ret;
	logic wb_valid;
	logic [7:0] wb_sn;
	logic [15:0] wb_data;
	logic wb_miss;
	logic flush;
	logic [7:0] flush_sn;

	// Front-end model state
	logic [31:0] lfsr;
	int credits;
	logic [7:0] next_sn;
	issue_pkg::op_e sent_op [256];
	logic [15:0] sent_a [256];
	logic [15:0] sent_b [256];
	logic sent_pred [256];
	// One bit per sn that was sent and has not written back yet
	logic [255:0] pending;

	// Compare process state
	int cycle_count = 0;
	logic flush_due = 1'b0;
	logic [7:0] due_sn = 8'd0;
	logic have_fc = 1'b0;
	logic [7:0] last_fc_sn = 8'd0;
	logic [16:0] exp_res;
	logic fc_op;

	issue_top dut_i (.clk, .rst_n, .in_valid, .in_op, .in_sn, .in_a, .in_b, .in_pred,
		.credit_ret, .wb_valid, .wb_sn, .wb_data, .wb_miss, .flush, .flush_sn);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ============================================================
	// Helpers
	// ============================================================

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s (got %0h, expected %0h)", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Takes n fresh bits, one LFSR step per bit
	task automatic draw(input int n, output logic [31:0] v);
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// True when sn x lies after sn y, modulo 256
	function automatic logic sn_after(input logic [7:0] x, input logic [7:0] y);
		logic [7:0] d;
		d = x - y;
		return (d != 8'd0) && (d < 8'd128);
	endfunction

	// Expected {miss, data} for one instruction
	function automatic logic [16:0] expected_result(input issue_pkg::op_e op,
		input logic [15:0] a, input logic [15:0] b, input logic pred);
		logic taken;
		logic [15:0] data;
		logic miss;
		taken = 1'b0;
		miss = 1'b0;
		case (op)
			issue_pkg::op_sub: data = a - b;
			issue_pkg::op_beq: taken = (a == b);
			issue_pkg::op_blt: taken = (a < b);
			default: data = a + b;
		endcase
		// Branches report the outcome and flag a wrong prediction
		if (op == issue_pkg::op_beq || op == issue_pkg::op_blt) begin
			data = {15'd0, taken};
			miss = (taken != pred);
		end
		return {miss, data};
	endfunction

	task automatic make_instr(input logic last, output issue_pkg::op_e op,
		output logic [15:0] a, output logic [15:0] b, output logic pred);
		logic [31:0] r;
		draw(3, r);
		case (r[2:0])
			3'd2: op = issue_pkg::op_sub;
			3'd3, 3'd4: op = issue_pkg::op_beq;
			3'd5: op = issue_pkg::op_blt;
			3'd6: op = issue_pkg::op_jmp;
			default: op = issue_pkg::op_add;
		endcase
		// A jmp at the very end would wait forever for its successor
		if (last)
			op = issue_pkg::op_add;
		if (op == issue_pkg::op_beq || op == issue_pkg::op_blt) begin
			// Narrow operands so both outcomes show up often
			draw(2, r);
			a = {14'd0, r[1:0]};
			draw(2, r);
			b = {14'd0, r[1:0]};
		end else begin
			draw(16, r);
			a = r[15:0];
			draw(16, r);
			b = r[15:0];
		end
		draw(1, r);
		pred = r[0];
	endtask

	// ============================================================
	// Front end, one clock per call
	// ============================================================
	task automatic cycle_step(input logic want, input issue_pkg::op_e op,
		input logic [15:0] a, input logic [15:0] b, input logic pred, output logic sent);
		logic [7:0] s;
		@(posedge clk);
		credits = credits + int'(credit_ret);
		check(32'(credits <= issue_pkg::IQ_ENTRIES), 32'd1,
			"front end holds more credits than queue entries");
		if (flush) begin
			// Everything sent after the branch is gone, resume right behind it
			for (s = flush_sn + 8'd1; s != next_sn; s++)
				pending[s] = 1'b0;
			next_sn = flush_sn + 8'd1;
		end
		sent = want && (credits > 0);
		if (sent) begin
			in_valid <= 1'b1;
			in_op <= op;
			in_sn <= next_sn;
			in_a <= a;
			in_b <= b;
			in_pred <= pred;
			sent_op[next_sn] = op;
			sent_a[next_sn] = a;
			sent_b[next_sn] = b;
			sent_pred[next_sn] = pred;
			pending[next_sn] = 1'b1;
			credits = credits - 1;
			next_sn = next_sn + 8'd1;
		end else begin
			in_valid <= 1'b0;
		end
	endtask

	task automatic idle_cycle();
		logic s;
		cycle_step(1'b0, issue_pkg::op_add, 16'd0, 16'd0, 1'b0, s);
	endtask

	// Waits until every sent instruction is written back, then checks credits
	task automatic drain();
		while (pending != '0)
			idle_cycle();
		repeat (3)
			idle_cycle();
		check(32'(credits), 32'(issue_pkg::IQ_ENTRIES),
			"credits did not return to the queue size after draining");
	endtask

	// ============================================================
	// Stimulus
	// ============================================================
	initial begin
		issue_pkg::op_e op;
		logic [15:0] a;
		logic [15:0] b;
		logic pred;
		logic [31:0] r;
		logic sent;
		int remaining;

		rst_n = 1'b0;
		in_valid = 1'b0;
		in_op = issue_pkg::op_add;
		in_sn = 8'd0;
		in_a = 16'd0;
		in_b = 16'd0;
		in_pred = 1'b0;
		lfsr = 32'h237c_82c8;
		credits = issue_pkg::IQ_ENTRIES;
		next_sn = 8'd0;
		pending = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// Random mix, sent on about three cycles in four
		remaining = N_RAND;
		while (remaining > 0) begin
			make_instr(remaining == 1, op, a, b, pred);
			draw(2, r);
			cycle_step(r[1:0] != 2'd0, op, a, b, pred, sent);
			if (sent)
				remaining = remaining - 1;
		end
		drain();

		// Lone jmp in an empty queue has no successor and must wait
		sent = 1'b0;
		while (!sent)
			cycle_step(1'b1, issue_pkg::op_jmp, 16'h1200, 16'h0034, 1'b0, sent);
		repeat (HOLD_CYCLES) begin
			idle_cycle();
			check(32'(wb_valid), 32'd0, "jmp wrote back before its successor arrived");
		end
		sent = 1'b0;
		while (!sent)
			cycle_step(1'b1, issue_pkg::op_sub, 16'h0050, 16'h0060, 1'b0, sent);
		drain();

		$display("Test completed successfully");
		$finish;
	end

	// ============================================================
	// Compare process
	// ============================================================
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with results still outstanding", cycle_count);
			$display("Test failed");
			$fatal(1, "Simulation stopped on timeout");
		end
		if (rst_n) begin
			// One flush pulse right after each mispredict, none otherwise
			check(32'(flush), 32'(flush_due), "flush pulse does not match the mispredicts");
			if (flush_due)
				check(32'(flush_sn), 32'(due_sn), "flush_sn differs from the branch sn");
			if (flush && wb_valid)
				check(32'(sn_after(wb_sn, flush_sn)), 32'd0,
					"younger result written back during the flush");
			if (wb_valid) begin
				check(32'(pending[wb_sn]), 32'd1,
					$sformatf("writeback for sn %0d that is not outstanding", wb_sn));
				exp_res = expected_result(sent_op[wb_sn], sent_a[wb_sn], sent_b[wb_sn],
					sent_pred[wb_sn]);
				check(32'(wb_data), 32'(exp_res[15:0]), $sformatf("data of sn %0d", wb_sn));
				check(32'(wb_miss), 32'(exp_res[16]), $sformatf("miss bit of sn %0d", wb_sn));
				fc_op = (sent_op[wb_sn] == issue_pkg::op_beq)
					|| (sent_op[wb_sn] == issue_pkg::op_blt)
					|| (sent_op[wb_sn] == issue_pkg::op_jmp);
				// Flow-control results leave the FCU strictly in program order
				if (fc_op) begin
					if (have_fc)
						check(32'(sn_after(wb_sn, last_fc_sn)), 32'd1,
							$sformatf("flow-control sn %0d out of order", wb_sn));
					last_fc_sn = wb_sn;
					have_fc = 1'b1;
				end
				pending[wb_sn] = 1'b0;
			end
			flush_due = wb_valid && wb_miss;
			due_sn = wb_sn;
		end
	end

endmodule

`default_nettype wire

// ==== issue_top.f ====
verilog/issue_pkg.sv
verilog/wb_if.sv
verilog/issue_queue.sv
verilog/fcu_issue.sv
verilog/fcu_unit.sv
verilog/alu_unit.sv
verilog/wb_arbiter.sv
verilog/issue_top.sv
bench/issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the issue slice with its testbench and run it under Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module issue_tb -Mdir obj_dir -f issue_top.f

status=0
out=$(./obj_dir/Vissue_tb) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
	exit 0
else
	exit 1
fi
